// ==== rv_core.f ====
rtl/rv_pkg.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/hazard_unit.sv
rtl/rv_core.sv
tests/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rv_core -f rv_core.f -o sim_rv_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_rv_core > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1

// ==== tests/tb_rv_core.sv ====
// Testbench for rv_core: memory models, program encoders, reference ISA model and store checker
`default_nettype none
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam addr_t RESET_PC   = 32'h0000_0100;
    localparam int RESET_CYCLES  = 10;
    localparam int TEST_CYCLES   = 800;
    localparam int SETTLE_CYCLES = 40;
    localparam int NUM_TESTS     = 4;
    localparam longint WATCHDOG_NS =
        longint'(NUM_TESTS * (RESET_CYCLES + 1 + TEST_CYCLES + SETTLE_CYCLES)) * 20 + 2000;

    logic      clk;
    logic      rst;
    addr_t     imem_addr;
    instr_t    imem_rdata;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    addr_t       exp_addr [$];
    word_t       exp_data [$];
    int          prog_len;
    int          st_idx;
    int          err_cnt;
    int          test_err;
    int          pass_cnt;
    int          fail_cnt;
    string       test_name;

    rv_core #(
        .RESET_PC (RESET_PC)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem_req.read ? dmem[dmem_req.addr[9:2]] : '0;

    ////////////////////////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////////////////////////
    function automatic instr_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                     reg_idx_t rs1, reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic instr_t enc_i(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                     logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic instr_t enc_lw(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'h03};
    endfunction

    function automatic instr_t enc_sw(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic instr_t enc_br(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                      logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic instr_t enc_jal(reg_idx_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6F};
    endfunction

    function automatic instr_t enc_lui(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, 7'h37};
    endfunction

    // Programs are placed at the reset PC
    function automatic void emit(instr_t ins);
        imem[RESET_PC[9:2] + prog_len] = ins;
        prog_len++;
    endfunction

    // Self loop that ends every program
    function automatic void emit_halt();
        emit(enc_jal(5'd0, 21'd0));
    endfunction

    function automatic void clear_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0013;
            // Every address bit takes part in the fill value
            dmem[i] = (i * 32'h9E37_79B1) ^ 32'h5A5A_0000 ^ (i << 20);
        end
        prog_len = 0;
    endfunction

    function automatic reg_idx_t rand_reg();
        return reg_idx_t'($urandom_range(7, 1));
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference ISA model
    ////////////////////////////////////////////////////////////
    function automatic void run_reference();
        word_t       rf [32];
        logic [31:0] mem [256];
        addr_t       pc;
        instr_t      ins;
        word_t       a;
        word_t       b;
        word_t       imm_i;
        word_t       imm_s;
        word_t       imm_b;
        word_t       imm_j;
        reg_idx_t    rd;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++) rf[i] = '0;
        for (int i = 0; i < 256; i++) mem[i] = dmem[i];
        pc = RESET_PC;
        for (int step = 0; step < 4000; step++) begin
            ins   = imem[pc[9:2]];
            if (ins == enc_jal(5'd0, 21'd0)) break;
            rd    = ins[11:7];
            a     = rf[ins[19:15]];
            b     = rf[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            case (ins[6:0])
                7'h37: rf[rd] = {ins[31:12], 12'b0};
                7'h13: begin
                    case (ins[14:12])
                        3'd2:    rf[rd] = {31'b0, $signed(a) < $signed(imm_i)};
                        3'd4:    rf[rd] = a ^ imm_i;
                        3'd6:    rf[rd] = a | imm_i;
                        3'd7:    rf[rd] = a & imm_i;
                        default: rf[rd] = a + imm_i;
                    endcase
                end
                7'h33: begin
                    case (ins[14:12])
                        3'd0:    rf[rd] = ins[30] ? a - b : a + b;
                        3'd1:    rf[rd] = a << b[4:0];
                        3'd2:    rf[rd] = {31'b0, $signed(a) < $signed(b)};
                        3'd4:    rf[rd] = a ^ b;
                        3'd5:    rf[rd] = a >> b[4:0];
                        3'd6:    rf[rd] = a | b;
                        default: rf[rd] = a & b;
                    endcase
                end
                7'h03: rf[rd] = mem[(a + imm_i) >> 2 & 32'hFF];
                7'h23: begin
                    exp_addr.push_back(a + imm_s);
                    exp_data.push_back(b);
                    mem[(a + imm_s) >> 2 & 32'hFF] = b;
                end
                default: ;
            endcase
            if (ins[6:0] == 7'h63 && ((a == b) ^ ins[12])) begin
                pc = pc + imm_b;
            end else if (ins[6:0] == 7'h6F) begin
                rf[rd] = pc + 32'd4;
                pc     = pc + imm_j;
            end else begin
                pc = pc + 32'd4;
            end
            rf[0] = '0;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Store checker and data memory writes
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            st_idx <= 0;
        end else if (dmem_req.write) begin
            if (st_idx >= exp_addr.size()) begin
                $display("%s: unexpected extra store to %h", test_name, dmem_req.addr);
                test_err++;
            end else if (dmem_req.addr != exp_addr[st_idx] ||
                         dmem_req.wdata != exp_data[st_idx]) begin
                $display("** Error %s: store %0d expected addr %h data %h, actual addr %h data %h",
                         test_name, st_idx, exp_addr[st_idx], exp_data[st_idx],
                         dmem_req.addr, dmem_req.wdata);
                test_err++;
            end
            dmem[dmem_req.addr[9:2]] = dmem_req.wdata;
            st_idx <= st_idx + 1;
        end
    end

    task automatic check_reset_state();
        if (imem_addr != RESET_PC) begin
            $display("** Error reset: imem_addr expected %h actual %h", RESET_PC, imem_addr);
            test_err++;
        end
        if (dmem_req.read || dmem_req.write) begin
            $display("** Error reset: dmem read/write expected 00 actual %b%b",
                     dmem_req.read, dmem_req.write);
            test_err++;
        end
    endtask

    task automatic run_test(string name);
        int cyc;
        test_name = name;
        test_err  = 0;
        run_reference();
        #2 rst = 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_reset_state();
            @(posedge clk);
        end
        #2 rst = 1'b0;
        @(negedge clk);
        check_reset_state();
        cyc = 0;
        while (st_idx < exp_addr.size() && cyc < TEST_CYCLES) begin
            @(posedge clk);
            cyc++;
        end
        if (st_idx < exp_addr.size()) begin
            $display("%s: only %0d of %0d stores seen before the test limit",
                     name, st_idx, exp_addr.size());
            test_err++;
        end
        // Give wrong-path stores a chance to show up
        repeat (SETTLE_CYCLES) @(posedge clk);
        if (st_idx != exp_addr.size()) begin
            $display("** Error %s: store count expected %0d actual %0d",
                     name, exp_addr.size(), st_idx);
            test_err++;
        end
        $display("%s: %s, %0d stores, %0d errors", name, test_err == 0 ? "pass" : "fail",
                 st_idx, test_err);
        err_cnt += test_err;
        if (test_err == 0) pass_cnt++;
        else fail_cnt++;
    endtask

    ////////////////////////////////////////////////////////////
    // Programs
    ////////////////////////////////////////////////////////////
    task automatic build_alu();
        reg_idx_t    rd;
        reg_idx_t    rs1;
        logic [2:0]  f3;
        int          k;
        clear_program();
        emit(enc_lui(5'd1, 20'($urandom())));
        emit(enc_i(3'd0, 5'd2, 5'd1, 12'($urandom())));
        for (int i = 3; i < 8; i++) emit(enc_i(3'd0, 5'(i), 5'(i - 1), 12'($urandom())));
        rs1 = 5'd7;
        k   = 0;
        for (int n = 0; n < 32; n++) begin
            rd = rand_reg();
            f3 = 3'($urandom());
            if ($urandom_range(1, 0) == 1) begin
                // SLTU is outside the supported subset
                if (f3 == 3'd3) begin
                    f3 = 3'd7;
                end
                emit(enc_r({1'b0, (f3 == 3'd0) ? 1'($urandom()) : 1'b0, 5'b0}, f3, rd, rs1,
                     rand_reg()));
            end else if (f3 == 3'd1 || f3 == 3'd5 || f3 == 3'd3) begin
                emit(enc_i(3'd0, rd, rs1, 12'($urandom())));
            end else begin
                emit(enc_i(f3, rd, rs1, 12'($urandom())));
            end
            // Skipping some stores leaves op-to-op EX/MEM forwarding
            if ($urandom_range(3, 0) != 0) begin
                emit(enc_sw(rd, 5'd0, 12'(32'h200 + 4 * k)));
                k++;
            end
            rs1 = rd;
        end
        emit_halt();
    endtask

    task automatic build_load_use();
        clear_program();
        for (int k = 0; k < 8; k++) begin
            emit(enc_lw(5'd5, 5'd0, 12'(4 * $urandom_range(63, 0))));
            emit(enc_i(3'd0, 5'd6, 5'd5, 12'($urandom())));
            emit(enc_sw(5'd6, 5'd0, 12'(32'h300 + 8 * k)));
            emit(enc_lw(5'd7, 5'd0, 12'(4 * $urandom_range(63, 0))));
            emit(enc_sw(5'd7, 5'd0, 12'(32'h304 + 8 * k)));
        end
        emit_halt();
    endtask

    task automatic build_branch();
        int loop_idx;
        clear_program();
        emit(enc_i(3'd0, 5'd1, 5'd0, 12'($urandom_range(6, 1))));
        emit(enc_i(3'd0, 5'd2, 5'd0, 12'($urandom_range(40, 0))));
        emit(enc_i(3'd0, 5'd7, 5'd0, 12'h7FF));
        loop_idx = prog_len;
        emit(enc_i(3'd0, 5'd2, 5'd2, 12'd3));
        emit(enc_sw(5'd2, 5'd0, 12'h200));
        emit(enc_i(3'd0, 5'd1, 5'd1, 12'hFFF));
        emit(enc_br(3'd1, 5'd1, 5'd0, 13'((loop_idx - prog_len) * 4)));
        // Not taken, then taken over two stores
        emit(enc_br(3'd0, 5'd2, 5'd0, 13'd16));
        emit(enc_sw(5'd1, 5'd0, 12'h204));
        emit(enc_br(3'd0, 5'd0, 5'd0, 13'd12));
        emit(enc_sw(5'd7, 5'd0, 12'h208));
        emit(enc_sw(5'd7, 5'd0, 12'h20C));
        emit(enc_sw(5'd2, 5'd0, 12'h210));
        emit_halt();
    endtask

    task automatic build_jal();
        clear_program();
        emit(enc_i(3'd0, 5'd3, 5'd0, 12'($urandom())));
        emit(enc_i(3'd0, 5'd4, 5'd3, 12'd1));
        emit(enc_jal(5'd5, 21'd12));
        emit(enc_sw(5'd3, 5'd0, 12'h240));
        emit(enc_sw(5'd3, 5'd0, 12'h244));
        emit(enc_sw(5'd5, 5'd0, 12'h248));
        emit(enc_jal(5'd6, 21'd8));
        emit(enc_sw(5'd4, 5'd0, 12'h24C));
        emit(enc_sw(5'd6, 5'd0, 12'h250));
        emit_halt();
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("Watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        void'($urandom(61));
        rst      = 1'b1;
        err_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        clear_program();
        @(posedge clk);
        build_alu();
        run_test("alu_forwarding");
        build_load_use();
        run_test("load_use");
        build_branch();
        run_test("branches");
        build_jal();
        run_test("jal");
        $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
// Top level of the five-stage RV32I pipeline, stage wiring and data memory request
`default_nettype none
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::addr_t RESET_PC = '0
) (
    input  wire logic            clk,
    input  wire logic            rst,
    output rv_pkg::addr_t        imem_addr_o,
    input  wire rv_pkg::instr_t  imem_rdata_i,
    output rv_pkg::dmem_req_t    dmem_req_o,
    input  wire rv_pkg::word_t   dmem_rdata_i
);
    import rv_pkg::*;

    addr_t     if_pc;
    instr_t    if_instr;
    logic      stall;
    logic      bubble;
    reg_idx_t  id_rs1;
    reg_idx_t  id_rs2;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    redirect_t redirect;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    logic      wb_we;
    reg_idx_t  wb_rd;
    word_t     wb_data;

    ////////////////////////////////////////////////////////////
    // Pipeline stages
    ////////////////////////////////////////////////////////////
    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk          (clk),
        .rst          (rst),
        .stall_i      (stall),
        .redirect_i   (redirect),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .if_pc_o      (if_pc),
        .if_instr_o   (if_instr)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst        (rst),
        .if_pc_i    (if_pc),
        .if_instr_i (if_instr),
        .bubble_i   (bubble),
        .wb_we_i    (wb_we),
        .wb_rd_i    (wb_rd),
        .wb_data_i  (wb_data),
        .id_rs1_o   (id_rs1),
        .id_rs2_o   (id_rs2),
        .id_ex_o    (id_ex)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rst        (rst),
        .id_ex_i    (id_ex),
        .fwd_a_i    (fwd_a),
        .fwd_b_i    (fwd_b),
        .wb_data_i  (wb_data),
        .redirect_o (redirect),
        .ex_mem_o   (ex_mem)
    );

    // MEM stage is just the external port
    assign dmem_req_o.addr  = ex_mem.alu_result;
    assign dmem_req_o.wdata = ex_mem.store_data;
    assign dmem_req_o.read  = ex_mem.mem_read;
    assign dmem_req_o.write = ex_mem.mem_write;

    writeback_stage u_writeback (
        .clk         (clk),
        .rst         (rst),
        .ex_mem_i    (ex_mem),
        .load_data_i (dmem_rdata_i),
        .wb_we_o     (wb_we),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data)
    );

    ////////////////////////////////////////////////////////////
    // Hazards and forwarding
    ////////////////////////////////////////////////////////////
    hazard_unit u_hazard (
        .id_rs1_i   (id_rs1),
        .id_rs2_i   (id_rs2),
        .id_ex_i    (id_ex),
        .ex_mem_i   (ex_mem),
        .wb_we_i    (wb_we),
        .wb_rd_i    (wb_rd),
        .redirect_i (redirect),
        .stall_o    (stall),
        .bubble_o   (bubble),
        .fwd_a_o    (fwd_a),
        .fwd_b_o    (fwd_b)
    );

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
// Forwarding selects, load-use stall detection and bubble insertion
`default_nettype none
`timescale 1ns/1ps

module hazard_unit (
    input  wire rv_pkg::reg_idx_t  id_rs1_i,
    input  wire rv_pkg::reg_idx_t  id_rs2_i,
    input  wire rv_pkg::id_ex_t    id_ex_i,
    input  wire rv_pkg::ex_mem_t   ex_mem_i,
    input  wire logic              wb_we_i,
    input  wire rv_pkg::reg_idx_t  wb_rd_i,
    input  wire rv_pkg::redirect_t redirect_i,
    output logic                   stall_o,
    output logic                   bubble_o,
    output rv_pkg::fwd_sel_e       fwd_a_o,
    output rv_pkg::fwd_sel_e       fwd_b_o
);
    import rv_pkg::*;

    logic load_use;

    // Younger result wins
    function automatic fwd_sel_e pick_fwd(reg_idx_t src);
        if (ex_mem_i.reg_write && ex_mem_i.rd != '0 && ex_mem_i.rd == src) return FWD_EXMEM;
        if (wb_we_i && wb_rd_i != '0 && wb_rd_i == src) return FWD_MEMWB;
        return FWD_RF;
    endfunction

    always_comb begin
        fwd_a_o = pick_fwd(id_ex_i.rs1_idx);
        fwd_b_o = pick_fwd(id_ex_i.rs2_idx);
    end

    // Load in EX feeding the instruction in ID
    assign load_use = id_ex_i.valid && id_ex_i.ctrl.mem_read && (id_ex_i.rd != '0) &&
                      ((id_ex_i.rd == id_rs1_i) || (id_ex_i.rd == id_rs2_i));

    assign stall_o  = load_use;
    assign bubble_o = load_use || redirect_i.taken;

endmodule

`default_nettype wire

// ==== rtl/writeback_stage.sv ====
// MEM/WB register and writeback data selection
`default_nettype none
`timescale 1ns/1ps

module writeback_stage (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire rv_pkg::ex_mem_t ex_mem_i,
    input  wire rv_pkg::word_t   load_data_i,
    output logic                 wb_we_o,
    output rv_pkg::reg_idx_t     wb_rd_o,
    output rv_pkg::word_t        wb_data_o
);
    import rv_pkg::*;

    mem_wb_t mem_wb_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.alu_result <= ex_mem_i.alu_result;
            mem_wb_q.load_data  <= load_data_i;
            mem_wb_q.rd         <= ex_mem_i.rd;
            mem_wb_q.mem_to_reg <= ex_mem_i.mem_read;
            // x0 writes dropped here so nothing downstream forwards them
            mem_wb_q.reg_write  <= ex_mem_i.reg_write && (ex_mem_i.rd != '0);
        end
    end

    assign wb_we_o   = mem_wb_q.reg_write;
    assign wb_rd_o   = mem_wb_q.rd;
    assign wb_data_o = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
// Operand forwarding, ALU, branch resolution and the EX/MEM register
`default_nettype none
`timescale 1ns/1ps

module execute_stage (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire rv_pkg::id_ex_t    id_ex_i,
    input  wire rv_pkg::fwd_sel_e  fwd_a_i,
    input  wire rv_pkg::fwd_sel_e  fwd_b_i,
    input  wire rv_pkg::word_t     wb_data_i,
    output rv_pkg::redirect_t      redirect_o,
    output rv_pkg::ex_mem_t        ex_mem_o
);
    import rv_pkg::*;

    ex_mem_t ex_mem_q;
    word_t   op_a;
    word_t   rs2_fwd;
    word_t   op_b;
    word_t   alu_res;
    word_t   result;
    logic    slt_bit;
    logic    br_eq;

    function automatic word_t pick_operand(fwd_sel_e sel, word_t rf_val);
        case (sel)
            FWD_EXMEM: return ex_mem_q.alu_result;
            FWD_MEMWB: return wb_data_i;
            default:   return rf_val;
        endcase
    endfunction

    always_comb begin
        op_a    = pick_operand(fwd_a_i, id_ex_i.rs1_val);
        rs2_fwd = pick_operand(fwd_b_i, id_ex_i.rs2_val);
    end

    assign op_b    = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rs2_fwd;
    assign slt_bit = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, slt_bit};
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // JAL links pc+4
    assign result = id_ex_i.ctrl.is_jal ? id_ex_i.pc + word_t'(4) : alu_res;

    ////////////////////////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////////////////////////
    assign br_eq             = (op_a == rs2_fwd);
    assign redirect_o.taken  = id_ex_i.valid && (id_ex_i.ctrl.is_jal ||
                               (id_ex_i.ctrl.is_branch && (br_eq ^ id_ex_i.ctrl.branch_ne)));
    assign redirect_o.target = id_ex_i.pc + id_ex_i.imm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.alu_result <= result;
            ex_mem_q.store_data <= rs2_fwd;
            ex_mem_q.rd         <= id_ex_i.rd;
            ex_mem_q.mem_read   <= id_ex_i.valid && id_ex_i.ctrl.mem_read;
            ex_mem_q.mem_write  <= id_ex_i.valid && id_ex_i.ctrl.mem_write;
            ex_mem_q.reg_write  <= id_ex_i.valid && id_ex_i.ctrl.reg_write;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
// Instruction decode, immediate generation, register file and the ID/EX register
`default_nettype none
`timescale 1ns/1ps

module decode_stage (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire rv_pkg::addr_t    if_pc_i,
    input  wire rv_pkg::instr_t   if_instr_i,
    input  wire logic             bubble_i,
    input  wire logic             wb_we_i,
    input  wire rv_pkg::reg_idx_t wb_rd_i,
    input  wire rv_pkg::word_t    wb_data_i,
    output rv_pkg::reg_idx_t      id_rs1_o,
    output rv_pkg::reg_idx_t      id_rs2_o,
    output rv_pkg::id_ex_t        id_ex_o
);
    import rv_pkg::*;

    opcode_e opcode;
    logic [2:0] funct3;
    ctrl_t   ctrl;
    word_t   imm;
    word_t   rs1_val;
    word_t   rs2_val;
    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;

    assign opcode   = opcode_e'(if_instr_i[6:0]);
    assign funct3   = if_instr_i[14:12];
    assign id_rs1_o = if_instr_i[19:15];
    assign id_rs2_o = if_instr_i[24:20];

    reg_file u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rs1_i      (id_rs1_o),
        .rs2_i      (id_rs2_o),
        .rs1_data_o (rs1_val),
        .rs2_data_o (rs2_val),
        .we_i       (wb_we_i),
        .rd_i       (wb_rd_i),
        .rd_data_i  (wb_data_i)
    );

    ////////////////////////////////////////////////////////////
    // Control and immediate decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        imm         = '0;
        case (opcode)
            OPC_LUI: begin
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = {if_instr_i[31:12], 12'b0};
            end
            OPC_OP_IMM: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
                case (funct3)
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = if_instr_i[30] ? ALU_SUB : ALU_ADD;
                    3'b001:  ctrl.alu_op = ALU_SLL;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b101:  ctrl.alu_op = ALU_SRL;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    default: ctrl.alu_op = ALU_AND;
                endcase
            end
            OPC_LOAD: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
            end
            OPC_STORE: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                imm = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
            end
            OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = funct3[0];
                imm = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                       if_instr_i[30:25], if_instr_i[11:8], 1'b0};
            end
            OPC_JAL: begin
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
                imm = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
                       if_instr_i[20], if_instr_i[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    // Bubble kills everything with a side effect
    always_comb begin
        id_ex_d.valid   = 1'b1;
        id_ex_d.pc      = if_pc_i;
        id_ex_d.rs1_val = rs1_val;
        id_ex_d.rs2_val = rs2_val;
        id_ex_d.rs1_idx = id_rs1_o;
        id_ex_d.rs2_idx = id_rs2_o;
        id_ex_d.rd      = if_instr_i[11:7];
        id_ex_d.imm     = imm;
        id_ex_d.ctrl    = ctrl;
        if (bubble_i) begin
            id_ex_d.valid          = 1'b0;
            id_ex_d.ctrl.mem_read  = 1'b0;
            id_ex_d.ctrl.mem_write = 1'b0;
            id_ex_d.ctrl.reg_write = 1'b0;
            id_ex_d.ctrl.is_branch = 1'b0;
            id_ex_d.ctrl.is_jal    = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

    a_no_read_write: assert property (@(posedge clk) disable iff (rst)
        id_ex_q.valid |-> !(id_ex_q.ctrl.mem_read && id_ex_q.ctrl.mem_write));

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// Integer register file, x0 tied to zero, write-first read bypass
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire rv_pkg::reg_idx_t rs1_i,
    input  wire rv_pkg::reg_idx_t rs2_i,
    output rv_pkg::word_t         rs1_data_o,
    output rv_pkg::word_t         rs2_data_o,
    input  wire logic             we_i,
    input  wire rv_pkg::reg_idx_t rd_i,
    input  wire rv_pkg::word_t    rd_data_i
);
    import rv_pkg::*;

    word_t regs_q [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs_q[rd_i] <= rd_data_i;
        end
    end

    // Writeback in the same cycle is seen by decode
    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0) return '0;
        if (we_i && rd_i == idx) return rd_data_i;
        return regs_q[idx];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
// Program counter, next-PC selection and the IF/ID register with flush
`default_nettype none
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv_pkg::addr_t RESET_PC = '0
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              stall_i,
    input  wire rv_pkg::redirect_t redirect_i,
    output rv_pkg::addr_t          imem_addr_o,
    input  wire rv_pkg::instr_t    imem_rdata_i,
    output rv_pkg::addr_t          if_pc_o,
    output rv_pkg::instr_t         if_instr_o
);
    import rv_pkg::*;

    addr_t  pc_q;
    addr_t  if_pc_q;
    instr_t if_instr_q;

    // Redirect wins over a load-use hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q       <= RESET_PC;
            if_pc_q    <= RESET_PC;
            if_instr_q <= NOP_INSTR;
        end else if (redirect_i.taken) begin
            pc_q       <= redirect_i.target;
            if_pc_q    <= pc_q;
            if_instr_q <= NOP_INSTR;
        end else if (!stall_i) begin
            pc_q       <= pc_q + addr_t'(4);
            if_pc_q    <= pc_q;
            if_instr_q <= imem_rdata_i;
        end
    end

    assign imem_addr_o = pc_q;
    assign if_pc_o     = if_pc_q;
    assign if_instr_o  = if_instr_q;

    // Branch and jump targets must keep the PC on a word boundary
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== rtl/rv_pkg.sv ====
// Widths, opcodes, ALU operations, forwarding selects and pipeline structs of rv_core
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;

    // ADDI x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_RF, FWD_EXMEM, FWD_MEMWB
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jal;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        word_t    rs1_val;
        word_t    rs2_val;
        reg_idx_t rs1_idx;
        reg_idx_t rs2_idx;
        reg_idx_t rd;
        word_t    imm;
        ctrl_t    ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
    } ex_mem_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    load_data;
        reg_idx_t rd;
        logic     mem_to_reg;
        logic     reg_write;
    } mem_wb_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } redirect_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  read;
        logic  write;
    } dmem_req_t;

endpackage

`default_nettype wire
